// ==== Makefile ====
# Verilator simulation of the calibration front end

VERILATOR ?= verilator
TOP       ?= calib_chain_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/calib_chain_tb.sv ====
// Calibration front end testbench
// Drives random sample streams into the calibration chain, predicts every
// packed word with a reference model of the offset, saturation and shift
// rules, and checks words, tags and the stability of stalled output
`include "calib_defines.svh"

module calib_chain_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [`CALIB_SHIFT_WIDTH-1:0] shift_t;

    localparam int SAMPLE_MAX = (1 << (`CALIB_DATA_WIDTH - 1)) - 1;
    localparam int SAMPLE_MIN = -(1 << (`CALIB_DATA_WIDTH - 1));

    // Sample ranges, the high and low ones always saturate with big offsets
    localparam int MODE_ANY  = 0;
    localparam int MODE_HIGH = 1;
    localparam int MODE_LOW  = 2;

    logic                    clock;
    logic                    reset;
    logic                    restart;
    calib_pkg::sample_t      offset;
    shift_t                  shift;
    logic                    gain_enable;
    logic                    in_valid;
    calib_pkg::sample_t      in_data;
    calib_pkg::dest_t        in_dest;
    logic                    in_ready;
    logic                    out_valid;
    calib_pkg::sample_pair_u out_word;
    calib_pkg::dest_t        out_dest;
    logic                    out_ready;

    // Expected words and tags in arrival order
    calib_pkg::sample_pair_u word_queue [$];
    calib_pkg::dest_t        dest_queue [$];
    logic                    model_half;
    calib_pkg::sample_t      first_data;
    calib_pkg::dest_t        first_dest;

    // Word seen while out_ready was low, it must still be there next edge
    logic                    stall_valid;
    calib_pkg::sample_pair_u stall_word;
    calib_pkg::dest_t        stall_dest;

    logic [31:0] lcg_state     = 32'hee8b27f4;
    string       test_name     = "reset";
    int          errors        = 0;
    int          total_words   = 0;
    int          tests_run     = 0;
    int          words_checked = 0;
    int          stable_checks = 0;
    logic        saw_ready_low = 1'b0;
    logic        stalled       = 1'b0;

    clock_gen u_clock_gen (
        .clock   (clock),
        .reset   (reset),
        .restart (restart)
    );

    calib_chain DUT (
        .clock       (clock),
        .reset       (reset),
        .offset      (offset),
        .shift       (shift),
        .gain_enable (gain_enable),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_dest     (in_dest),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_word    (out_word),
        .out_dest    (out_dest),
        .out_ready   (out_ready)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic calib_pkg::sample_t small_offset();
        return calib_pkg::sample_t'(int'(next_random() % 512) - 256);
    endfunction

    // High samples span 0x1000 to 0x7fff, low ones 0x8000 to 0xefff
    function automatic calib_pkg::sample_t make_sample(input int mode);
        if (mode == MODE_HIGH) begin
            return calib_pkg::sample_t'(32'h1000 + next_random() % 32'h7000);
        end else if (mode == MODE_LOW) begin
            return calib_pkg::sample_t'(32'h8000 + next_random() % 32'h7000);
        end
        return calib_pkg::sample_t'(next_random() >> 7);
    endfunction

    // Offset sum clamped to the sample range, then shifted and wrapped
    function automatic calib_pkg::sample_t expected_sample(input calib_pkg::sample_t data);
        int sum;
        sum = int'(data) + int'(offset);
        if (sum > SAMPLE_MAX) begin
            sum = SAMPLE_MAX;
        end else if (sum < SAMPLE_MIN) begin
            sum = SAMPLE_MIN;
        end
        if (gain_enable) begin
            sum = sum << shift;
        end
        return calib_pkg::sample_t'(sum);
    endfunction

    task automatic check_word(input string label, input calib_pkg::sample_pair_u expected,
                              input calib_pkg::sample_pair_u actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %h actual %h", test_name, label,
                     expected.word, actual.word);
            errors++;
        end
    endtask

    task automatic check_dest(input string label, input calib_pkg::dest_t expected,
                              input calib_pkg::dest_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %h actual %h", test_name, label, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string label, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %b actual %b", test_name, label, expected, actual);
            errors++;
        end
    endtask

    // Reference model and scoreboard, sampled on every rising edge
    always @(posedge clock) begin : scoreboard
        calib_pkg::sample_t      cal;
        calib_pkg::sample_pair_u expected_word;
        if (!reset) begin
            word_queue.delete();
            dest_queue.delete();
            model_half    = 1'b0;
            stall_valid   = 1'b0;
            saw_ready_low = 1'b0;
            words_checked = 0;
            stable_checks = 0;
        end else begin
            if (!in_ready) begin
                saw_ready_low = 1'b1;
            end
            if (stall_valid && !out_valid) begin
                $display("%s: out_valid dropped while out_ready was low", test_name);
                errors++;
            end else if (stall_valid) begin
                check_word("stalled word", stall_word, out_word);
                check_dest("stalled tag", stall_dest, out_dest);
                stable_checks++;
            end
            stall_valid = out_valid && !out_ready;
            stall_word  = out_word;
            stall_dest  = out_dest;
            if (out_valid && out_ready) begin
                if (word_queue.size() == 0) begin
                    $display("%s: a word arrived when none was expected", test_name);
                    errors++;
                end else begin
                    check_word("word", word_queue.pop_front(), out_word);
                    check_dest("tag", dest_queue.pop_front(), out_dest);
                    words_checked++;
                    total_words++;
                end
            end
            // First sample of a pair goes to lo and lends the word its tag
            if (in_valid && in_ready) begin
                cal = expected_sample(in_data);
                if (!model_half) begin
                    first_data = cal;
                    first_dest = in_dest;
                    model_half = 1'b1;
                end else begin
                    expected_word.lanes.lo = first_data;
                    expected_word.lanes.hi = cal;
                    word_queue.push_back(expected_word);
                    dest_queue.push_back(first_dest);
                    model_half = 1'b0;
                end
            end
        end
    end

    // Follows one reset from its first edge to the first edge after it.
    // The first reset edge still shows out_valid from before the reset,
    // while in_ready is forced high at once
    task automatic watch_reset();
        int cycles;
        cycles = 0;
        while (!stalled) begin
            @(posedge clock);
            check_bit("in_ready", 1'b1, in_ready);
            if (cycles > 0) begin
                check_bit("out_valid", 1'b0, out_valid);
            end
            if (reset) begin
                break;
            end
            cycles++;
            if (cycles > 20) begin
                $display("stall in %s: reset was never released", test_name);
                stalled = 1'b1;
            end
        end
    endtask

    // Out of reset, the chain is empty and upstream is free to send. The
    // second reset starts with the FIFO full, so only the reset override
    // can hold in_ready high on its first edge
    task automatic check_reset();
        int cycles;
        int errors_at_start;
        errors_at_start = errors;
        test_name = "reset";
        watch_reset();
        in_valid  <= 1'b1;
        out_ready <= 1'b0;
        cycles = 0;
        while (!stalled) begin
            @(posedge clock);
            if (!in_ready) begin
                break;
            end
            cycles++;
            if (cycles > 40) begin
                $display("stall in reset: in_ready never dropped with the output blocked");
                stalled = 1'b1;
            end
        end
        in_valid <= 1'b0;
        restart  <= 1'b1;
        @(posedge clock);
        restart <= 1'b0;
        watch_reset();
        tests_run++;
        $display("%s finished: %0d errors", test_name, errors - errors_at_start);
    endtask

    task automatic apply_reset(input calib_pkg::sample_t new_offset, input shift_t new_shift,
                               input logic new_gain);
        int cycles;
        @(posedge clock);
        offset      <= new_offset;
        shift       <= new_shift;
        gain_enable <= new_gain;
        in_valid    <= 1'b0;
        out_ready   <= 1'b0;
        restart     <= 1'b1;
        @(posedge clock);
        restart <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
        end while (!reset && cycles < 20);
        if (!reset) begin
            $display("stall in %s: reset was never released", test_name);
            stalled = 1'b1;
        end
    endtask

    task automatic run_stream(input string name, input calib_pkg::sample_t new_offset,
                              input shift_t new_shift, input logic new_gain, input int mode,
                              input int samples, input int ready_pct, input logic pressure);
        int sent;
        int cycles;
        int errors_at_start;
        if (stalled) begin
            return;
        end
        test_name = name;
        errors_at_start = errors;
        apply_reset(new_offset, new_shift, new_gain);
        sent = 0;
        cycles = 0;
        while (sent < samples && !stalled) begin
            @(posedge clock);
            if (in_valid && in_ready) begin
                sent++;
            end
            // A refused sample stays on the bus until it is taken
            if (in_valid && !in_ready) begin
                in_valid <= 1'b1;
            end else if (sent < samples && next_random() % 4 != 0) begin
                in_valid <= 1'b1;
                in_data  <= make_sample(mode);
                in_dest  <= calib_pkg::dest_t'(next_random() >> 11);
            end else begin
                in_valid <= 1'b0;
            end
            out_ready <= (next_random() % 100) < ready_pct;
            cycles++;
            if (cycles > samples * 40 + 200) begin
                $display("stall in %s: only %0d of %0d samples accepted", name, sent, samples);
                stalled = 1'b1;
            end
        end
        // Drain whatever is still in the chain
        @(posedge clock);
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while ((word_queue.size() != 0 || model_half || out_valid) && cycles < 200);
        if (word_queue.size() != 0 || model_half || out_valid) begin
            $display("stall in %s: %0d words never arrived", name, word_queue.size());
            stalled = 1'b1;
        end
        if (pressure && !saw_ready_low) begin
            $display("%s: in_ready never dropped under back-pressure", name);
            errors++;
        end
        if (pressure && stable_checks == 0) begin
            $display("%s: no stalled output word was observed", name);
            errors++;
        end
        tests_run++;
        $display("%s finished: %0d words checked, %0d errors", name, words_checked,
                 errors - errors_at_start);
    endtask

    initial begin
        restart     = 1'b0;
        offset      = '0;
        shift       = '0;
        gain_enable = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        in_dest     = '0;
        out_ready   = 1'b0;

        check_reset();
        run_stream("offset_pass", small_offset(), '0, 1'b0, MODE_ANY, 200, 80, 1'b0);
        run_stream("saturate_high", 16'sh7000, '0, 1'b0, MODE_HIGH, 100, 80, 1'b0);
        run_stream("saturate_low", -16'sh7000, '0, 1'b0, MODE_LOW, 100, 80, 1'b0);
        for (int i = 0; i < 4; i++) begin
            run_stream($sformatf("shift_gain_%0d", i), small_offset(), shift_t'(next_random()),
                       1'b1, MODE_ANY, 50, 80, 1'b0);
        end
        run_stream("back_pressure", small_offset(), '0, 1'b0, MODE_ANY, 200, 30, 1'b1);
        run_stream("stable_output", small_offset(), shift_t'(next_random()), 1'b1, MODE_ANY,
                   100, 40, 1'b1);

        $display("tests run %0d, words checked %0d, errors %0d", tests_run, total_words,
                 errors);
        if (errors == 0 && !stalled) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== dv/clock_gen.sv ====
// Testbench clock and reset source
// Free running 20 ns clock. Reset is held low for 5 rising edges at
// start-up and again whenever restart is seen high on a rising edge
module clock_gen (
    output logic clock,
    output logic reset,
    input  logic restart
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 5;

    // Edges of reset still to go, reset is released when it reaches zero
    int hold_count = RESET_CYCLES;

    initial begin
        clock = 1'b0;
    end

    always #HALF_PERIOD clock = ~clock;

    always @(posedge clock) begin
        if (restart) begin
            hold_count <= RESET_CYCLES;
        end else if (hold_count != 0) begin
            hold_count <= hold_count - 1;
        end
    end

    assign reset = (hold_count == 0);

endmodule

// ==== rtl/calib_chain.sv ====
// Calibration front end top level
// Calibration feeds the sample FIFO, and the lane packer drains it into
// 32-bit words for the downstream bus
`include "calib_defines.svh"

module calib_chain (
    input  logic                          clock,
    input  logic                          reset,
    input  calib_pkg::sample_t            offset,
    input  logic [`CALIB_SHIFT_WIDTH-1:0] shift,
    input  logic                          gain_enable,
    input  logic                          in_valid,
    input  calib_pkg::sample_t            in_data,
    input  calib_pkg::dest_t              in_dest,
    output logic                          in_ready,
    output logic                          out_valid,
    output calib_pkg::sample_pair_u       out_word,
    output calib_pkg::dest_t              out_dest,
    input  logic                          out_ready
);

    // Calibration to FIFO
    logic               cal_valid;
    calib_pkg::sample_t cal_data;
    calib_pkg::dest_t   cal_dest;
    logic               fifo_ready;

    // FIFO to packer
    logic               fifo_valid;
    calib_pkg::sample_t fifo_data;
    calib_pkg::dest_t   fifo_dest;
    logic               pop;

    calibration u_calibration (
        .clock       (clock),
        .reset       (reset),
        .offset      (offset),
        .shift       (shift),
        .gain_enable (gain_enable),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_dest     (in_dest),
        .in_ready    (in_ready),
        .cal_valid   (cal_valid),
        .cal_data    (cal_data),
        .cal_dest    (cal_dest),
        .fifo_ready  (fifo_ready)
    );

    sample_fifo u_sample_fifo (
        .clock    (clock),
        .reset    (reset),
        .wr_valid (cal_valid),
        .wr_data  (cal_data),
        .wr_dest  (cal_dest),
        .wr_ready (fifo_ready),
        .rd_valid (fifo_valid),
        .rd_data  (fifo_data),
        .rd_dest  (fifo_dest),
        .rd_ready (pop)
    );

    lane_packer u_lane_packer (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (fifo_valid),
        .in_data   (fifo_data),
        .in_dest   (fifo_dest),
        .in_ready  (pop),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_dest  (out_dest),
        .out_ready (out_ready)
    );

endmodule

// ==== rtl/calib_defines.svh ====
// Calibration front end parameters
// Widths of the sample path, the channel tag and the gain shift amount,
// plus the number of entries in the sample FIFO
`ifndef CALIB_DEFINES_SVH
`define CALIB_DEFINES_SVH

// Signed sample width on the input stream and inside the FIFO
`define CALIB_DATA_WIDTH 16

// Channel tag width, carried alongside every sample
`define CALIB_DEST_WIDTH 4

// Shift amount width for the gain stage, shifts of 0 to 15
`define CALIB_SHIFT_WIDTH 4

// FIFO entries, must be a power of two
`define CALIB_FIFO_DEPTH 8

`endif

// ==== rtl/calib_pkg.sv ====
// Calibration front end types
// Sample and channel tag types, and the two-lane word that the packer
// builds and the downstream bus carries
`include "calib_defines.svh"

package calib_pkg;

    // One signed sample as it moves through the chain
    typedef logic signed [`CALIB_DATA_WIDTH-1:0] sample_t;

    // Channel tag that travels with each sample
    typedef logic [`CALIB_DEST_WIDTH-1:0] dest_t;

    // Two samples side by side, the older one sits in lo
    typedef struct packed {
        sample_t hi;
        sample_t lo;
    } lanes_t;

    // The packer writes the lanes, the bus reads the flat word
    typedef union packed {
        logic [2*`CALIB_DATA_WIDTH-1:0] word;
        lanes_t                         lanes;
    } sample_pair_u;

endpackage

// ==== rtl/calibration.sv ====
// Calibration stage
// Adds a signed offset with saturation to each accepted sample and, with
// gain enabled, shifts the result left. The result is registered one
// cycle after acceptance and shown as a single-cycle valid pulse
`include "calib_defines.svh"

module calibration (
    input  logic                          clock,
    input  logic                          reset,
    input  calib_pkg::sample_t            offset,
    input  logic [`CALIB_SHIFT_WIDTH-1:0] shift,
    input  logic                          gain_enable,
    input  logic                          in_valid,
    input  calib_pkg::sample_t            in_data,
    input  calib_pkg::dest_t              in_dest,
    output logic                          in_ready,
    output logic                          cal_valid,
    output calib_pkg::sample_t            cal_data,
    output calib_pkg::dest_t              cal_dest,
    input  logic                          fifo_ready
);

    calib_pkg::sample_t offset_sum;
    logic               accept;

    // Upstream may push while the FIFO has room, and always while in reset
    assign in_ready = fifo_ready | ~reset;
    assign accept   = in_valid & in_ready;

    saturating_adder offset_adder (
        .a   (in_data),
        .b   (offset),
        .sum (offset_sum)
    );

    // Valid pulses for one cycle per sample and never waits on the FIFO,
    // the FIFO keeps a spare slot for exactly this sample
    always_ff @(posedge clock) begin
        if (!reset) begin
            cal_valid <= 1'b0;
        end else begin
            cal_valid <= accept;
        end
    end

    // Payload register, the shifted value keeps only the low bits and wraps
    always_ff @(posedge clock) begin
        if (accept) begin
            if (gain_enable) begin
                cal_data <= offset_sum << shift;
            end else begin
                cal_data <= offset_sum;
            end
            cal_dest <= in_dest;
        end
    end

endmodule

// ==== rtl/lane_packer.sv ====
// Lane packer
// Pairs consecutive samples into one two-lane word for the wider bus. The
// first sample waits in a hold register, the second one completes the
// word, which then stays in the output register until it is taken
module lane_packer (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    in_valid,
    input  calib_pkg::sample_t      in_data,
    input  calib_pkg::dest_t        in_dest,
    output logic                    in_ready,
    output logic                    out_valid,
    output calib_pkg::sample_pair_u out_word,
    output calib_pkg::dest_t        out_dest,
    input  logic                    out_ready
);

    // Set while the first sample of a pair is held
    logic               half;
    calib_pkg::sample_t hold_data;
    calib_pkg::dest_t   hold_dest;
    logic               pop;
    logic               complete;

    // Stop popping while a finished word sits unclaimed, the output
    // register may be refilled on the same edge it drains
    assign in_ready = !out_valid || out_ready;
    assign pop      = in_valid && in_ready;
    assign complete = pop && half;

    always_ff @(posedge clock) begin
        if (!reset) begin
            half      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (pop) begin
                half <= !half;
            end
            if (complete) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Hold register for the first sample and its tag
    always_ff @(posedge clock) begin
        if (pop && !half) begin
            hold_data <= in_data;
            hold_dest <= in_dest;
        end
    end

    // Older sample goes to lo, newer to hi, the word carries the first tag
    always_ff @(posedge clock) begin
        if (complete) begin
            out_word.lanes.lo <= hold_data;
            out_word.lanes.hi <= in_data;
            out_dest          <= hold_dest;
        end
    end

endmodule

// ==== rtl/sample_fifo.sv ====
// Sample FIFO
// Circular buffer of calibrated samples with their channel tags. The read
// side is first-word-fall-through. Write ready drops one entry early so
// that a sample already registered upstream still has a slot
`include "calib_defines.svh"

module sample_fifo (
    input  logic               clock,
    input  logic               reset,
    input  logic               wr_valid,
    input  calib_pkg::sample_t wr_data,
    input  calib_pkg::dest_t   wr_dest,
    output logic               wr_ready,
    output logic               rd_valid,
    output calib_pkg::sample_t rd_data,
    output calib_pkg::dest_t   rd_dest,
    input  logic               rd_ready
);

    localparam int DEPTH    = `CALIB_FIFO_DEPTH;
    localparam int PTR_W    = $clog2(DEPTH);
    localparam int COUNT_W  = PTR_W + 1;

    localparam logic [COUNT_W-1:0] FULL_COUNT    = COUNT_W'(DEPTH);
    localparam logic [COUNT_W-1:0] RESERVE_COUNT = COUNT_W'(DEPTH - 1);

    calib_pkg::sample_t data_mem [DEPTH];
    calib_pkg::dest_t   dest_mem [DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               do_write;
    logic               do_read;

    // Ready is only a request to stop, a write arriving while ready is low
    // is still stored as long as a slot is free
    assign wr_ready = (count < RESERVE_COUNT);
    assign do_write = wr_valid && (count != FULL_COUNT);

    assign rd_valid = (count != '0);
    assign do_read  = rd_valid && rd_ready;

    // Head entry is visible without a read strobe
    assign rd_data = data_mem[rd_ptr];
    assign rd_dest = dest_mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_write) begin
            data_mem[wr_ptr] <= wr_data;
            dest_mem[wr_ptr] <= wr_dest;
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // A read and a write together leave the count as it is
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== rtl/saturating_adder.sv ====
// Saturating signed adder
// Adds two samples and clamps to the most positive or most negative
// sample value instead of wrapping on overflow
module saturating_adder (
    input  calib_pkg::sample_t a,
    input  calib_pkg::sample_t b,
    output calib_pkg::sample_t sum
);

    localparam int W = $bits(calib_pkg::sample_t);

    // Clamp values follow from the sample width
    localparam logic [W-1:0] SAT_POS = {1'b0, {(W-1){1'b1}}};
    localparam logic [W-1:0] SAT_NEG = {1'b1, {(W-1){1'b0}}};

    // Sum with one guard bit, so its top bit is always the true sign
    logic [W:0] sum_wide;
    logic       overflow;

    assign sum_wide = {a[W-1], a} + {b[W-1], b};

    // Overflow only happens when both operands share a sign and the
    // truncated result comes out with the other sign
    assign overflow = (a[W-1] == b[W-1]) && (sum_wide[W-1] != a[W-1]);

    always_comb begin
        if (!overflow) begin
            sum = sum_wide[W-1:0];
        end else if (sum_wide[W]) begin
            sum = SAT_NEG;
        end else begin
            sum = SAT_POS;
        end
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/calib_pkg.sv
rtl/saturating_adder.sv
rtl/calibration.sv
rtl/sample_fifo.sv
rtl/lane_packer.sv
rtl/calib_chain.sv
dv/clock_gen.sv
dv/calib_chain_tb.sv
